/* common/filter_defines.svh */
`ifndef FILTER_DEFINES_SVH
`define FILTER_DEFINES_SVH

// edge of the square filter window
`define FILTER_KERNEL_SIZE 3

// depth of one row memory
// every hcount value of a line must fit below this
`define FILTER_MAX_LINE 2048

// RGB565 field widths
// red sits on top and blue in the low bits
`define FILTER_R_BITS 5
`define FILTER_G_BITS 6
`define FILTER_B_BITS 5

// a full pixel is the three fields packed together
// so these three must add up to the pixel width

`endif

/* common/video_pkg.sv */
`include "filter_defines.svh"

// types for the pixel stream and its raster position
package video_pkg;

  // one RGB565 pixel
  // red in the top bits, green in the middle, blue at the bottom
  typedef logic [`FILTER_R_BITS+`FILTER_G_BITS+`FILTER_B_BITS-1:0] pixel_t;

  // lowest bit of each colour field inside pixel_t
  localparam int unsigned PIX_G_LSB = `FILTER_B_BITS;
  localparam int unsigned PIX_R_LSB = `FILTER_B_BITS + `FILTER_G_BITS;

  // column counter, wide enough to address a whole row memory
  typedef logic [$clog2(`FILTER_MAX_LINE)-1:0] hcount_t;

  // row counter
  typedef logic [9:0] vcount_t;

endpackage

/* common/filter_pkg.sv */
`include "filter_defines.svh"

// types for the kernel and the host configuration words
package filter_pkg;

  // taps per kernel, stored row-major with the top-left tap at index 0
  localparam int unsigned NUM_COEFFS = `FILTER_KERNEL_SIZE * `FILTER_KERNEL_SIZE;
  localparam int unsigned CENTRE_INDEX = NUM_COEFFS / 2;

  typedef logic signed [7:0] coeff_t;
  typedef logic [3:0] shift_t;
  typedef coeff_t [NUM_COEFFS-1:0] coeff_array_t;

  // bit 15 of a config word picks how the rest is read
  localparam logic CFG_SEL_COEFF = 1'b0;
  localparam logic CFG_SEL_SHIFT = 1'b1;

  // coefficient write
  typedef struct packed {
    logic       sel;
    logic [2:0] unused;
    logic [3:0] index;
    coeff_t     value;
  } cfg_coeff_t;

  // shift write
  typedef struct packed {
    logic        sel;
    logic [10:0] unused;
    shift_t      amount;
  } cfg_shift_t;

  typedef union packed {
    cfg_coeff_t coeff_view;
    cfg_shift_t shift_view;
  } cfg_word_u;

  // pass-through kernel, only the centre tap set to one
  localparam coeff_array_t IDENTITY_KERNEL =
    coeff_array_t'(1) << (CENTRE_INDEX * $bits(coeff_t));

endpackage

/* rtl/delay_pipe.sv */
`timescale 1ns/10ps

module delay_pipe #(
  parameter int STAGES = 1,
  parameter int WIDTH  = 1
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  // stage 0 takes the input, the last stage drives the output
  logic [WIDTH-1:0] stage [STAGES];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= data_in;
      for (int i = 1; i < STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign data_out = stage[STAGES-1];

endmodule

/* line_buffer/line_buffer.sv */
`timescale 1ns/10ps
`include "filter_defines.svh"

module line_buffer (
  input  logic               clk_in,
  input  logic               rst_in,
  input  video_pkg::pixel_t  pixel_in,
  input  video_pkg::hcount_t hcount_in,
  input  video_pkg::vcount_t vcount_in,
  input  logic               pixel_valid,
  output video_pkg::pixel_t  col_top,
  output video_pkg::pixel_t  col_mid,
  output video_pkg::pixel_t  col_bot,
  output video_pkg::hcount_t col_hcount,
  output video_pkg::vcount_t col_vcount,
  output logic               col_valid
);
  import video_pkg::*;

  // older row holds line vcount-2
  pixel_t row_old [`FILTER_MAX_LINE];
  // newer row holds line vcount-1
  pixel_t row_new [`FILTER_MAX_LINE];

  // both memories are read at hcount before this cycle's write lands
  // so the column sees the previous two lines at the same x
  always_ff @(posedge clk_in) begin
    if (pixel_valid) begin
      // top of the column comes from two lines back
      col_top <= row_old[hcount_in];
      // middle from the line just above
      col_mid <= row_new[hcount_in];
      // bottom is the pixel arriving now
      col_bot <= pixel_in;
      // counters ride along with their column
      col_hcount <= hcount_in;
      col_vcount <= vcount_in;

      // roll the rows at this x
      // the newer entry ages into the older row
      row_old[hcount_in] <= row_new[hcount_in];
      // and the incoming pixel becomes the newer entry
      row_new[hcount_in] <= pixel_in;
    end
  end

  // column strobe follows the input strobe by one cycle
  // gaps in the input show up as gaps here
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      col_valid <= 1'b0;
    end else begin
      col_valid <= pixel_valid;
    end
  end

  // no row index register is needed
  // each x position keeps its own two-deep history
  // which advances once per line at that x
  // a line shorter than the previous one leaves stale entries past its end
  // and those only feed border windows

endmodule

/* convolution/kernel_regs.sv */
`timescale 1ns/10ps

module kernel_regs (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     cfg_req,
  input  filter_pkg::cfg_word_u    cfg_word,
  output logic                     cfg_ack,
  output filter_pkg::coeff_array_t coeffs,
  output filter_pkg::shift_t       shift
);
  import filter_pkg::*;

  // fields of the incoming word in both views
  logic       word_sel;
  logic [3:0] word_index;
  coeff_t     word_coeff;
  shift_t     word_shift;
  // a request is taken once, on the cycle ack goes up
  logic       take_word;

  // bit 15 is the same bit in either view
  assign word_sel   = cfg_word.coeff_view.sel;
  assign word_index = cfg_word.coeff_view.index;
  assign word_coeff = cfg_word.coeff_view.value;
  assign word_shift = cfg_word.shift_view.amount;

  assign take_word = cfg_req && !cfg_ack;

  // four-phase ack
  // ack follows req one cycle later in both directions
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cfg_ack <= 1'b0;
    end else if (take_word) begin
      cfg_ack <= 1'b1;
    end else if (!cfg_req && cfg_ack) begin
      cfg_ack <= 1'b0;
    end
  end

  // register file
  // starts as the identity kernel with no shift
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      coeffs <= IDENTITY_KERNEL;
      shift  <= '0;
    end else if (take_word) begin
      case (word_sel)
        CFG_SEL_SHIFT: begin
          shift <= word_shift;
        end
        CFG_SEL_COEFF: begin
          // indices past the last tap match nothing and are dropped
          for (int i = 0; i < NUM_COEFFS; i++) begin
            if (word_index == 4'(i)) begin
              coeffs[i] <= word_coeff;
            end
          end
        end
      endcase
    end
  end

endmodule

/* convolution/convolution.sv */
`timescale 1ns/10ps
`include "filter_defines.svh"

module convolution (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  video_pkg::pixel_t        col_top,
  input  video_pkg::pixel_t        col_mid,
  input  video_pkg::pixel_t        col_bot,
  input  video_pkg::hcount_t       col_hcount,
  input  video_pkg::vcount_t       col_vcount,
  input  logic                     col_valid,
  input  filter_pkg::coeff_array_t coeffs,
  input  filter_pkg::shift_t       shift,
  output video_pkg::pixel_t        pixel_out,
  output video_pkg::hcount_t       hcount_out,
  output video_pkg::vcount_t       vcount_out,
  output logic                     out_valid
);
  import video_pkg::*;

  localparam int KS = `FILTER_KERNEL_SIZE;
  localparam int NUM_CH = 3;
  // window, products with row sums, total with shift and clip
  localparam int PIPE_STAGES = 3;
  // 9-bit zero-extended channel times 8-bit signed tap
  localparam int PROD_W = 17;
  // headroom for nine products
  localparam int SUM_W = PROD_W + 4;

  // window[row][col], row 0 is the oldest line, col 0 the leftmost x
  pixel_t                   window  [KS][KS];
  logic signed [PROD_W-1:0] prod    [NUM_CH][KS][KS];
  logic signed [SUM_W-1:0]  row_sum [NUM_CH][KS];
  logic signed [SUM_W-1:0]  total   [NUM_CH];
  logic signed [SUM_W-1:0]  scaled  [NUM_CH];
  logic [7:0]               clipped [NUM_CH];
  pixel_t                   pixel_next;
  hcount_t                  centre_hcount;
  vcount_t                  centre_vcount;

  // channel 0 red, 1 green, 2 blue, zero-extended to a byte
  function automatic logic [7:0] chan_field(input pixel_t pix, input int ch);
    case (ch)
      0:       chan_field = 8'(pix[PIX_R_LSB +: `FILTER_R_BITS]);
      1:       chan_field = 8'(pix[PIX_G_LSB +: `FILTER_G_BITS]);
      default: chan_field = 8'(pix[0 +: `FILTER_B_BITS]);
    endcase
  endfunction

  // largest value the channel field can hold
  function automatic logic signed [SUM_W-1:0] chan_max(input int ch);
    case (ch)
      0:       chan_max = SUM_W'((1 << `FILTER_R_BITS) - 1);
      1:       chan_max = SUM_W'((1 << `FILTER_G_BITS) - 1);
      default: chan_max = SUM_W'((1 << `FILTER_B_BITS) - 1);
    endcase
  endfunction

  // stage 1 shifts the new column in from the right
  // window only moves on a valid column
  always_ff @(posedge clk_in) begin
    if (col_valid) begin
      for (int r = 0; r < KS; r++) begin
        for (int c = 0; c < KS - 1; c++) begin
          window[r][c] <= window[r][c+1];
        end
      end
      window[0][KS-1] <= col_top;
      window[1][KS-1] <= col_mid;
      window[2][KS-1] <= col_bot;
    end
  end

  // one signed product per tap and channel
  // taps are indexed row-major to match the register file
  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      for (int r = 0; r < KS; r++) begin
        for (int c = 0; c < KS; c++) begin
          prod[ch][r][c] = $signed({1'b0, chan_field(window[r][c], ch)}) *
                           $signed(coeffs[r*KS+c]);
        end
      end
    end
  end

  // stage 2 registers the first adder level, one sum per window row
  always_ff @(posedge clk_in) begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      for (int r = 0; r < KS; r++) begin
        row_sum[ch][r] <= prod[ch][r][0] + prod[ch][r][1] + prod[ch][r][2];
      end
    end
  end

  // second adder level, then arithmetic shift and clip to the field
  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      total[ch]  = row_sum[ch][0] + row_sum[ch][1] + row_sum[ch][2];
      scaled[ch] = total[ch] >>> shift;
      if (scaled[ch] < 0) begin
        clipped[ch] = '0;
      end else if (scaled[ch] > chan_max(ch)) begin
        clipped[ch] = 8'(chan_max(ch));
      end else begin
        clipped[ch] = 8'(scaled[ch]);
      end
    end
  end

  assign pixel_next = {clipped[0][`FILTER_R_BITS-1:0],
                       clipped[1][`FILTER_G_BITS-1:0],
                       clipped[2][`FILTER_B_BITS-1:0]};

  // stage 3 registers the finished pixel
  always_ff @(posedge clk_in) begin
    pixel_out <= pixel_next;
  end

  // the window centre is one pixel left of and one line above the newest column
  assign centre_hcount = col_hcount - 1'b1;
  assign centre_vcount = col_vcount - 1'b1;

  delay_pipe #(
    .STAGES(PIPE_STAGES),
    .WIDTH ($bits(hcount_t))
  ) hcount_pipe (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .data_in (centre_hcount),
    .data_out(hcount_out)
  );

  delay_pipe #(
    .STAGES(PIPE_STAGES),
    .WIDTH ($bits(vcount_t))
  ) vcount_pipe (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .data_in (centre_vcount),
    .data_out(vcount_out)
  );

  // valid runs every cycle so gaps keep their spacing
  delay_pipe #(
    .STAGES(PIPE_STAGES),
    .WIDTH (1)
  ) valid_pipe (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .data_in (col_valid),
    .data_out(out_valid)
  );

endmodule

/* rtl/filter_top.sv */
`timescale 1ns/10ps

module filter_top (
  input  logic                  clk_in,
  input  logic                  rst_in,
  // pixel stream in
  input  video_pkg::pixel_t     pixel_in,
  input  video_pkg::hcount_t    hcount_in,
  input  video_pkg::vcount_t    vcount_in,
  input  logic                  pixel_valid,
  // filtered stream out, 4 cycles behind the input
  output video_pkg::pixel_t     pixel_out,
  output video_pkg::hcount_t    hcount_out,
  output video_pkg::vcount_t    vcount_out,
  output logic                  out_valid,
  // host config port
  input  logic                  cfg_req,
  input  filter_pkg::cfg_word_u cfg_word,
  output logic                  cfg_ack
);
  import video_pkg::*;
  import filter_pkg::*;

  // three-pixel column from the line buffer
  pixel_t       col_top;
  pixel_t       col_mid;
  pixel_t       col_bot;
  hcount_t      col_hcount;
  vcount_t      col_vcount;
  logic         col_valid;
  // current kernel
  coeff_array_t coeffs;
  shift_t       shift;

  line_buffer line_buffer_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pixel_in   (pixel_in),
    .hcount_in  (hcount_in),
    .vcount_in  (vcount_in),
    .pixel_valid(pixel_valid),
    .col_top    (col_top),
    .col_mid    (col_mid),
    .col_bot    (col_bot),
    .col_hcount (col_hcount),
    .col_vcount (col_vcount),
    .col_valid  (col_valid)
  );

  kernel_regs kernel_regs_inst (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .cfg_req (cfg_req),
    .cfg_word(cfg_word),
    .cfg_ack (cfg_ack),
    .coeffs  (coeffs),
    .shift   (shift)
  );

  convolution convolution_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .col_top   (col_top),
    .col_mid   (col_mid),
    .col_bot   (col_bot),
    .col_hcount(col_hcount),
    .col_vcount(col_vcount),
    .col_valid (col_valid),
    .coeffs    (coeffs),
    .shift     (shift),
    .pixel_out (pixel_out),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .out_valid (out_valid)
  );

endmodule

/* sim/filter_chk.sv */
`timescale 1ns/10ps

module filter_chk #(
  parameter bit HAS_HANDSHAKE = 1'b1
) (
  input logic clk_in,
  input logic rst_in,
  input logic req,
  input logic ack,
  input logic valid
);

  // bumped by every failing assertion, read by the testbench at the end
  int assert_failures = 0;

  // the handshake pair only exists where req and ack are real signals
  if (HAS_HANDSHAKE) begin : handshake_props
    // ack can only go up on the edge where req was seen high
    ack_rise_needs_req: assert property (
      @(posedge clk_in) disable iff (rst_in) !req |=> !$rose(ack)
    ) else begin
      assert_failures++;
      $error("cfg_ack rose while cfg_req was low");
    end

    // once up, ack holds until req has dropped
    ack_holds_while_req: assert property (
      @(posedge clk_in) disable iff (rst_in) (ack && req) |=> ack
    ) else begin
      assert_failures++;
      $error("cfg_ack fell before cfg_req fell");
    end
  end

  // strobe is cleared by reset
  low_after_reset: assert property (
    @(posedge clk_in) rst_in |=> !valid
  ) else begin
    assert_failures++;
    $error("strobe high in the cycle after reset");
  end

endmodule

// handshake side of the kernel registers
bind kernel_regs filter_chk #(.HAS_HANDSHAKE(1'b1)) handshake_chk (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .req   (cfg_req),
  .ack   (cfg_ack),
  .valid (cfg_ack)
);

// output strobe of the convolution which has no handshake
bind convolution filter_chk #(.HAS_HANDSHAKE(1'b0)) stream_chk (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .req   (1'b0),
  .ack   (1'b0),
  .valid (out_valid)
);

/* sim/filter_tb.sv */
`timescale 1ns/10ps

module filter_tb;
  import video_pkg::*;
  import filter_pkg::*;

  localparam int FRAME_W = 12;
  localparam int FRAME_H = 8;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
  localparam int WAIT_LIMIT = 200;
  localparam int LATENCY = 4;

  logic      clk_in;
  logic      rst_in;
  pixel_t    pixel_in;
  hcount_t   hcount_in;
  vcount_t   vcount_in;
  logic      pixel_valid;
  pixel_t    pixel_out;
  hcount_t   hcount_out;
  vcount_t   vcount_out;
  logic      out_valid;
  logic      cfg_req;
  cfg_word_u cfg_word;
  logic      cfg_ack;

  // software copy of the kernel and of the current frame
  coeff_t model_coeff [9];
  shift_t model_shift;
  pixel_t frame [FRAME_H][FRAME_W];
  // how often the model clipped a channel at each end
  int     clipped_low;
  int     clipped_high;
  int     cycle_count;
  // one entry per output beat, plus the cycle of each input beat
  pixel_t  out_pix [$];
  hcount_t out_h [$];
  vcount_t out_v [$];
  int      out_cyc [$];
  int      in_cyc [$];
  pixel_t  saved_pix [$];

  filter_top uut (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pixel_in   (pixel_in),
    .hcount_in  (hcount_in),
    .vcount_in  (vcount_in),
    .pixel_valid(pixel_valid),
    .pixel_out  (pixel_out),
    .hcount_out (hcount_out),
    .vcount_out (vcount_out),
    .out_valid  (out_valid),
    .cfg_req    (cfg_req),
    .cfg_word   (cfg_word),
    .cfg_ack    (cfg_ack)
  );

  always #20 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
  end

  // outputs are picked up mid-cycle well away from the edges
  always @(negedge clk_in) begin
    if (!rst_in && out_valid) begin
      out_pix.push_back(pixel_out);
      out_h.push_back(hcount_out);
      out_v.push_back(vcount_out);
      out_cyc.push_back(cycle_count);
    end
  end

  task automatic halt_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input int idx);
    if (got !== exp) begin
      $display("FAIL %0t: pixel %0d got %h expected %h", $time, idx, got, exp);
      halt_run();
    end
  endtask

  task automatic check_hcount(input hcount_t got, input hcount_t exp, input int idx);
    if (got !== exp) begin
      $display("FAIL %0t: hcount of pixel %0d got %0d expected %0d", $time, idx, got, exp);
      halt_run();
    end
  endtask

  task automatic check_vcount(input vcount_t got, input vcount_t exp, input int idx);
    if (got !== exp) begin
      $display("FAIL %0t: vcount of pixel %0d got %0d expected %0d", $time, idx, got, exp);
      halt_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      halt_run();
    end
  endtask

  task automatic check_latency(input int got, input int exp, input int idx);
    if (got != exp) begin
      $display("FAIL %0t: latency of pixel %0d got %0d expected %0d", $time, idx, got, exp);
      halt_run();
    end
  endtask

  // one channel of the window sum around (cx, cy), shifted but not clipped
  function automatic int model_channel(input int ch, input int cx, input int cy);
    int     sum;
    int     field;
    pixel_t p;
    sum = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        p = frame[cy-1+r][cx-1+c];
        case (ch)
          0: field = int'(p[15:11]);
          1: field = int'(p[10:5]);
          default: field = int'(p[4:0]);
        endcase
        sum += field * int'(model_coeff[r*3+c]);
      end
    end
    return sum >>> model_shift;
  endfunction

  function automatic pixel_t expected_pixel(input int cx, input int cy);
    int         limit [3] = '{31, 63, 31};
    int         value;
    logic [5:0] chans [3];
    for (int ch = 0; ch < 3; ch++) begin
      value = model_channel(ch, cx, cy);
      if (value < 0) begin
        value = 0;
        clipped_low++;
      end else if (value > limit[ch]) begin
        value = limit[ch];
        clipped_high++;
      end
      chans[ch] = 6'(value);
    end
    return {chans[0][4:0], chans[1], chans[2][4:0]};
  endfunction

  task automatic randomize_frame();
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        frame[v][h] = pixel_t'($urandom);
      end
    end
  endtask

  task automatic wait_ack(input logic level);
    int waited;
    waited = 0;
    while (cfg_ack !== level) begin
      if (waited >= WAIT_LIMIT) begin
        $display("timeout while waiting for cfg_ack to reach %b", level);
        halt_run();
      end else begin
        @(posedge clk_in);
        #2;
        waited++;
      end
    end
  endtask

  // full four-phase transfer of one config word
  task automatic send_word(input cfg_word_u word);
    wait_ack(1'b0);
    @(posedge clk_in);
    #2;
    cfg_word = word;
    cfg_req  = 1'b1;
    wait_ack(1'b1);
    cfg_req = 1'b0;
    wait_ack(1'b0);
  endtask

  // coefficient word has sel 0 with the index in bits 11..8 and the value in 7..0
  task automatic load_coeff(input int idx, input coeff_t value);
    send_word(cfg_word_u'({1'b0, 3'b000, 4'(idx), value}));
    if (idx < 9) begin
      model_coeff[idx] = value;
    end
  endtask

  task automatic load_shift(input shift_t amount);
    send_word(cfg_word_u'({1'b1, 11'h000, amount}));
    model_shift = amount;
  endtask

  // stream the frame row by row with optional random idle cycles
  task automatic run_frame(input bit gaps);
    int waited;
    int gap;
    out_pix.delete();
    out_h.delete();
    out_v.delete();
    out_cyc.delete();
    in_cyc.delete();
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        gap = gaps ? int'($urandom_range(2, 0)) : 0;
        repeat (gap) begin
          @(posedge clk_in);
          #2;
          pixel_valid = 1'b0;
        end
        @(posedge clk_in);
        #2;
        pixel_in    = frame[v][h];
        hcount_in   = hcount_t'(h);
        vcount_in   = vcount_t'(v);
        pixel_valid = 1'b1;
        in_cyc.push_back(cycle_count);
      end
    end
    @(posedge clk_in);
    #2;
    pixel_valid = 1'b0;
    waited = 0;
    while (out_pix.size() < FRAME_PIXELS) begin
      if (waited >= WAIT_LIMIT) begin
        $display("timeout while waiting for the filtered frame");
        halt_run();
      end else begin
        @(posedge clk_in);
        #2;
        waited++;
      end
    end
    // no extra beats may trail the frame
    repeat (8) @(posedge clk_in);
    #2;
    if (out_pix.size() != FRAME_PIXELS) begin
      $display("got %0d output pixels for %0d input pixels", out_pix.size(), FRAME_PIXELS);
      halt_run();
    end
  endtask

  // counters and latency on every beat but pixels only on interior centres
  task automatic check_frame(input bit passthrough);
    int     h;
    int     v;
    pixel_t exp_pix;
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      h = i % FRAME_W;
      v = i / FRAME_W;
      check_hcount(out_h[i], hcount_t'(h - 1), i);
      check_vcount(out_v[i], vcount_t'(v - 1), i);
      check_latency(out_cyc[i] - in_cyc[i], LATENCY, i);
      if (h >= 2 && v >= 2) begin
        exp_pix = passthrough ? frame[v-1][h-1] : expected_pixel(h - 1, v - 1);
        check_pixel(out_pix[i], exp_pix, i);
      end
    end
  endtask

  task automatic compare_saved();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      if (i % FRAME_W >= 2 && i / FRAME_W >= 2) begin
        check_pixel(out_pix[i], saved_pix[i], i);
      end
    end
  endtask

  task automatic test_reset_identity();
    repeat (8) begin
      @(posedge clk_in);
      #2;
      check_flag(out_valid, 1'b0, "out_valid after reset");
      check_flag(cfg_ack, 1'b0, "cfg_ack after reset");
    end
    randomize_frame();
    run_frame(1'b0);
    check_frame(1'b1);
  endtask

  task automatic test_box_blur();
    for (int k = 0; k < 9; k++) begin
      load_coeff(k, coeff_t'(1));
    end
    load_shift(shift_t'(3));
    randomize_frame();
    run_frame(1'b0);
    check_frame(1'b0);
  endtask

  // laplacian style kernel swings far past both ends of each field
  task automatic test_edge_clip();
    for (int k = 0; k < 9; k++) begin
      load_coeff(k, k == 4 ? coeff_t'(8) : coeff_t'(-1));
    end
    load_shift(shift_t'(0));
    randomize_frame();
    clipped_low  = 0;
    clipped_high = 0;
    run_frame(1'b0);
    check_frame(1'b0);
    if (clipped_low == 0 || clipped_high == 0) begin
      $display("edge kernel did not reach both clip limits");
      halt_run();
    end
  endtask

  // taps 9 to 15 do not exist so the output must not move
  task automatic test_bad_index();
    run_frame(1'b0);
    saved_pix = out_pix;
    load_coeff(9, coeff_t'(77));
    load_coeff(12, coeff_t'(-5));
    load_coeff(15, coeff_t'(127));
    run_frame(1'b0);
    check_frame(1'b0);
    compare_saved();
  endtask

  task automatic test_valid_gaps();
    randomize_frame();
    run_frame(1'b0);
    saved_pix = out_pix;
    run_frame(1'b1);
    check_frame(1'b0);
    compare_saved();
  endtask

  initial begin
    int failures;
    void'($urandom(32'h7af6c7fd));
    rst_in      = 1'b1;
    clk_in      = 1'b0;
    pixel_in    = '0;
    hcount_in   = '0;
    vcount_in   = '0;
    pixel_valid = 1'b0;
    cfg_req     = 1'b0;
    cfg_word    = '0;
    cycle_count = 0;
    // identity kernel, as after reset
    for (int k = 0; k < 9; k++) begin
      model_coeff[k] = (k == 4) ? coeff_t'(1) : coeff_t'(0);
    end
    model_shift = '0;
    repeat (2) @(posedge clk_in);
    #2;
    rst_in = 1'b0;

    test_reset_identity();
    test_box_blur();
    test_edge_clip();
    test_bad_index();
    test_valid_gaps();

    failures = uut.kernel_regs_inst.handshake_chk.assert_failures +
               uut.convolution_inst.stream_chk.assert_failures;
    if (failures == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("%0d concurrent assertion failures", failures);
      halt_run();
    end
  end

endmodule

/* sources.f */
+incdir+common
common/video_pkg.sv
common/filter_pkg.sv
rtl/delay_pipe.sv
line_buffer/line_buffer.sv
convolution/kernel_regs.sv
convolution/convolution.sv
rtl/filter_top.sv
sim/filter_chk.sv
sim/filter_tb.sv

/* Makefile */
# Verilator build and run for the 3x3 filter testbench

VERILATOR ?= verilator
TOP       ?= filter_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK
VFLAGS    ?= -Wno-fatal
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		-f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
